//--- design/gate_array_top.sv
/*
 * multi-lane length gate: command scheduler, one gate per lane, packet merger
 * lane input vectors are indexed by lane number
 * output latency depends on arbitration and back-pressure
 */
`timescale 1ns/1ps

module gate_array_top #(
        parameter int                num_lanes = gate_cfg_pkg::num_lanes,
        parameter int                data_w    = gate_cfg_pkg::data_w,
        parameter int                len_w     = gate_cfg_pkg::len_w,
        parameter int                tag_w     = gate_cfg_pkg::tag_w,
        parameter int                lane_w    = gate_cfg_pkg::lane_w,
        parameter logic [data_w-1:0] pad_word  = gate_cfg_pkg::pad_word
) (
        input  logic                             clk,
        input  logic                             reset,

        input  logic [lane_w-1:0]                cmd_lane,
        input  logic [len_w-1:0]                 cmd_len,
        input  logic [tag_w-1:0]                 cmd_tag,
        input  logic                             cmd_valid,
        output logic                             cmd_ready,

        input  logic [num_lanes-1:0][data_w-1:0] lane_data,
        input  logic [num_lanes-1:0]             lane_last,
        input  logic [num_lanes-1:0]             lane_valid,
        output logic [num_lanes-1:0]             lane_ready,

        output logic [data_w-1:0]                m_data,
        output logic                             m_first,
        output logic                             m_last,
        output logic [tag_w-1:0]                 m_tag,
        output logic                             m_valid,
        input  logic                             m_ready
);

        logic [num_lanes-1:0][len_w-1:0]  permit_len;
        logic [num_lanes-1:0][tag_w-1:0]  permit_tag;
        logic [num_lanes-1:0]             permit_valid;
        logic [num_lanes-1:0]             permit_ready;

        logic [num_lanes-1:0][data_w-1:0] gate_data;
        logic [num_lanes-1:0]             gate_first;
        logic [num_lanes-1:0]             gate_last;
        logic [num_lanes-1:0][tag_w-1:0]  gate_tag;
        logic [num_lanes-1:0]             gate_valid;
        logic [num_lanes-1:0]             gate_ready;

        permit_scheduler #(
                .num_lanes (num_lanes),
                .len_w     (len_w),
                .tag_w     (tag_w),
                .lane_w    (lane_w)
        ) scheduler_i (
                .clk, .reset, .cmd_lane, .cmd_len, .cmd_tag, .cmd_valid, .cmd_ready,
                .permit_len, .permit_tag, .permit_valid, .permit_ready
        );

        for (genvar i = 0; i < num_lanes; i++) begin : g_lane
                stream_gate #(
                        .data_w   (data_w),
                        .len_w    (len_w),
                        .tag_w    (tag_w),
                        .pad_word (pad_word)
                ) gate_i (
                        .clk          (clk),
                        .reset        (reset),
                        .permit_len   (permit_len[i]),
                        .permit_tag   (permit_tag[i]),
                        .permit_valid (permit_valid[i]),
                        .permit_ready (permit_ready[i]),
                        .lane_data    (lane_data[i]),
                        .lane_last    (lane_last[i]),
                        .lane_valid   (lane_valid[i]),
                        .lane_ready   (lane_ready[i]),
                        .out_data     (gate_data[i]),
                        .out_first    (gate_first[i]),
                        .out_last     (gate_last[i]),
                        .out_tag      (gate_tag[i]),
                        .out_valid    (gate_valid[i]),
                        .out_ready    (gate_ready[i])
                );
        end

        packet_merger #(
                .num_lanes (num_lanes),
                .data_w    (data_w),
                .tag_w     (tag_w)
        ) merger_i (
                .clk      (clk),
                .reset    (reset),
                .in_data  (gate_data),
                .in_first (gate_first),
                .in_last  (gate_last),
                .in_tag   (gate_tag),
                .in_valid (gate_valid),
                .in_ready (gate_ready),
                .m_data, .m_first, .m_last, .m_tag, .m_valid, .m_ready
        );

endmodule

//--- design/gate_cfg_pkg.sv
/*
 * sizing constants for the multi-lane length gate
 * lane_w must be wide enough to index num_lanes
 * pad_word is 32 bits and is cut to data_w where it is used
 */
package gate_cfg_pkg;

        // ------------------------------
        // stream widths
        // ------------------------------
        localparam int data_w = 32;
        localparam int len_w  = 8;
        localparam int tag_w  = 8;

        // ------------------------------
        // lanes
        // ------------------------------
        localparam int num_lanes = 4;
        localparam int lane_w    = 2;

        // fill word for short input packets
        localparam logic [31:0] pad_word = 32'hDEADBEEF;

endpackage

//--- design/gate_types_pkg.sv
/*
 * field types of commands, permits and lane words
 * a len_t value of n asks for n+1 words
 * widths follow gate_cfg_pkg, so overrides at the top must agree with it
 */
package gate_types_pkg;

        typedef logic [gate_cfg_pkg::data_w-1:0] data_t;
        typedef logic [gate_cfg_pkg::len_w-1:0]  len_t;
        typedef logic [gate_cfg_pkg::tag_w-1:0]  tag_t;
        typedef logic [gate_cfg_pkg::lane_w-1:0] lane_t;

        // one pending permit, held per lane in the scheduler
        typedef struct packed {
                len_t len;
                tag_t tag;
        } permit_t;

        // one lane input word with its packet end flag
        typedef struct packed {
                data_t data;
                logic  last;
        } lane_word_t;

endpackage

//--- design/packet_merger.sv
/*
 * round-robin merge of the lane outputs, one whole packet at a time
 * a grant is held from a lane's first word until its last word
 * the output is registered: one cycle from lane transfer to m_valid
 */
`timescale 1ns/1ps

module packet_merger #(
        parameter int num_lanes = gate_cfg_pkg::num_lanes,
        parameter int data_w    = gate_cfg_pkg::data_w,
        parameter int tag_w     = gate_cfg_pkg::tag_w
) (
        input  logic                             clk,
        input  logic                             reset,

        input  logic [num_lanes-1:0][data_w-1:0] in_data,
        input  logic [num_lanes-1:0]             in_first,
        input  logic [num_lanes-1:0]             in_last,
        input  logic [num_lanes-1:0][tag_w-1:0]  in_tag,
        input  logic [num_lanes-1:0]             in_valid,
        output logic [num_lanes-1:0]             in_ready,

        output logic [data_w-1:0]                m_data,
        output logic                             m_first,
        output logic                             m_last,
        output logic [tag_w-1:0]                 m_tag,
        output logic                             m_valid,
        input  logic                             m_ready
);

        localparam int idx_w = (num_lanes > 1) ? $clog2(num_lanes) : 1;

        logic [idx_w-1:0] rr_ptr;
        logic [idx_w-1:0] grant;
        logic             locked;
        logic [idx_w-1:0] sel;
        logic             sel_valid;
        logic             take;
        logic             xfer;

        // ------------------------------
        // lane select
        // ------------------------------
        always_comb begin
                int unsigned idx;
                sel       = grant;
                sel_valid = 1'b0;
                idx       = 0;
                if (locked) begin
                        sel_valid = in_valid[grant];
                end else begin
                        // first lane with valid, counting from rr_ptr
                        for (int k = 0; k < num_lanes; k++) begin
                                idx = (int'(rr_ptr) + k) % num_lanes;
                                if (!sel_valid && in_valid[idx]) begin
                                        sel       = idx_w'(idx);
                                        sel_valid = 1'b1;
                                end
                        end
                end
        end

        assign take = !m_valid || m_ready;
        assign xfer = take && sel_valid;

        always_comb begin
                in_ready      = '0;
                in_ready[sel] = take;
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        m_valid <= 1'b0;
                        locked  <= 1'b0;
                        grant   <= '0;
                        rr_ptr  <= '0;
                end else if (xfer) begin
                        m_valid <= 1'b1;
                        grant   <= sel;
                        locked  <= !in_last[sel];
                        if (in_last[sel]) begin
                                rr_ptr <= (sel == idx_w'(num_lanes - 1)) ? '0 : sel + 1'b1;
                        end
                end else if (m_ready) begin
                        m_valid <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (xfer) begin
                        m_data  <= in_data[sel];
                        m_first <= in_first[sel];
                        m_last  <= in_last[sel];
                        m_tag   <= in_tag[sel];
                end
        end

endmodule

//--- design/permit_scheduler.sv
/*
 * routes each command to the permit port of the lane it names
 * one permit is held per lane; a command for a lane whose permit
 * has not been taken stalls the command stream
 */
`timescale 1ns/1ps

module permit_scheduler #(
        parameter int num_lanes = gate_cfg_pkg::num_lanes,
        parameter int len_w     = gate_cfg_pkg::len_w,
        parameter int tag_w     = gate_cfg_pkg::tag_w,
        parameter int lane_w    = gate_cfg_pkg::lane_w
) (
        input  logic                            clk,
        input  logic                            reset,

        input  logic [lane_w-1:0]               cmd_lane,
        input  logic [len_w-1:0]                cmd_len,
        input  logic [tag_w-1:0]                cmd_tag,
        input  logic                            cmd_valid,
        output logic                            cmd_ready,

        output logic [num_lanes-1:0][len_w-1:0] permit_len,
        output logic [num_lanes-1:0][tag_w-1:0] permit_tag,
        output logic [num_lanes-1:0]            permit_valid,
        input  logic [num_lanes-1:0]            permit_ready
);

        import gate_types_pkg::*;

        permit_t              cmd_permit;
        logic [num_lanes-1:0] stage_valid;
        logic [num_lanes-1:0] stage_ready;

        assign cmd_permit = '{len: cmd_len, tag: cmd_tag};

        // ready follows the addressed lane only
        assign cmd_ready = stage_ready[cmd_lane];

        // ------------------------------
        // per-lane permit holding stage
        // ------------------------------
        for (genvar i = 0; i < num_lanes; i++) begin : g_lane
                permit_t held;

                assign stage_valid[i] = cmd_valid && (cmd_lane == lane_t'(i));

                skid_stage #(
                        .payload_t (permit_t)
                ) permit_skid_i (
                        .clk       (clk),
                        .reset     (reset),
                        .s_payload (cmd_permit),
                        .s_valid   (stage_valid[i]),
                        .s_ready   (stage_ready[i]),
                        .m_payload (held),
                        .m_valid   (permit_valid[i]),
                        .m_ready   (permit_ready[i])
                );

                assign permit_len[i] = held.len;
                assign permit_tag[i] = held.tag;
        end

endmodule

//--- design/skid_stage.sv
/*
 * one-entry registered valid/ready stage
 * refills in the cycle its word leaves, so back to back transfers run at full rate
 * s_ready is low while reset is high
 */
`timescale 1ns/1ps

module skid_stage #(
        parameter type payload_t = logic
) (
        input  logic     clk,
        input  logic     reset,

        input  payload_t s_payload,
        input  logic     s_valid,
        output logic     s_ready,

        output payload_t m_payload,
        output logic     m_valid,
        input  logic     m_ready
);

        logic load;

        // room when empty or when the held word leaves now
        assign s_ready = !reset && (!m_valid || m_ready);
        assign load    = s_valid && s_ready;

        always_ff @(posedge clk) begin
                if (reset) begin
                        m_valid <= 1'b0;
                end else if (load) begin
                        m_valid <= 1'b1;
                end else if (m_ready) begin
                        m_valid <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (load) begin
                        m_payload <= s_payload;
                end
        end

endmodule

//--- design/stream_gate.sv
/*
 * counted gate for one lane: passes exactly len+1 words per permit
 * a short packet is filled with pad_word, a long one is dropped to its last word
 * one permit at a time; a new permit is taken only while idle
 */
`timescale 1ns/1ps

module stream_gate #(
        parameter int                data_w   = gate_cfg_pkg::data_w,
        parameter int                len_w    = gate_cfg_pkg::len_w,
        parameter int                tag_w    = gate_cfg_pkg::tag_w,
        parameter logic [data_w-1:0] pad_word = gate_cfg_pkg::pad_word
) (
        input  logic              clk,
        input  logic              reset,

        input  logic [len_w-1:0]  permit_len,
        input  logic [tag_w-1:0]  permit_tag,
        input  logic              permit_valid,
        output logic              permit_ready,

        input  logic [data_w-1:0] lane_data,
        input  logic              lane_last,
        input  logic              lane_valid,
        output logic              lane_ready,

        output logic [data_w-1:0] out_data,
        output logic              out_first,
        output logic              out_last,
        output logic [tag_w-1:0]  out_tag,
        output logic              out_valid,
        input  logic              out_ready
);

        import gate_types_pkg::*;

        lane_word_t       lane_word;
        lane_word_t       in_word;
        logic             in_valid;
        logic             in_ready;

        logic             busy;
        logic [len_w-1:0] remain;
        logic             start;
        logic             at_end;
        logic             padding;
        logic             drain;
        logic [tag_w-1:0] tag;

        logic             permit_xfer;
        logic             out_xfer;
        logic             in_xfer;

        assign lane_word = '{data: lane_data, last: lane_last};

        skid_stage #(
                .payload_t (lane_word_t)
        ) lane_skid_i (
                .clk       (clk),
                .reset     (reset),
                .s_payload (lane_word),
                .s_valid   (lane_valid),
                .s_ready   (lane_ready),
                .m_payload (in_word),
                .m_valid   (in_valid),
                .m_ready   (in_ready)
        );

        // ------------------------------
        // handshakes
        // ------------------------------
        assign permit_ready = !busy;
        assign out_valid    = busy && !drain && (padding || in_valid);
        assign out_data     = padding ? pad_word : in_word.data;
        assign out_first    = start;
        assign out_last     = at_end;
        assign out_tag      = tag;

        // surplus words are read and dropped while draining
        assign in_ready     = drain || (busy && !padding && out_ready);

        assign permit_xfer  = permit_valid && permit_ready;
        assign out_xfer     = out_valid && out_ready;
        assign in_xfer      = in_valid && in_ready;

        always_ff @(posedge clk) begin
                if (reset) begin
                        busy    <= 1'b0;
                        start   <= 1'b0;
                        at_end  <= 1'b0;
                        padding <= 1'b0;
                        drain   <= 1'b0;
                end else begin
                        if (permit_xfer) begin
                                busy    <= 1'b1;
                                start   <= 1'b1;
                                at_end  <= (permit_len == '0);
                                padding <= 1'b0;
                        end else if (out_xfer) begin
                                start <= 1'b0;
                                if (at_end) begin
                                        busy    <= 1'b0;
                                        padding <= 1'b0;
                                        // count done before the input packet ended
                                        drain   <= !padding && !in_word.last;
                                end else begin
                                        at_end  <= (remain == len_w'(1));
                                        padding <= padding || in_word.last;
                                end
                        end
                        if (drain && in_xfer && in_word.last) begin
                                drain <= 1'b0;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (permit_xfer) begin
                        remain <= permit_len;
                        tag    <= permit_tag;
                end else if (out_xfer && !at_end) begin
                        remain <= remain - 1'b1;
                end
        end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing -Wno-fatal --top-module gate_array_tb \
        -Mdir obj_dir -f verilog.f; then
        echo "verilator build failed"
        exit 1
fi

if ! ./obj_dir/Vgate_array_tb > "$log" 2>&1; then
        cat "$log"
        echo "simulation binary returned an error status"
        exit 1
fi

cat "$log"

if grep -q "Simulation failed" "$log"; then
        exit 1
fi
exit 0

//--- verification/gate_array_tb.sv
/*
 * directed tests for gate_array_top at its default parameters
 * expected words are built from the gate rules: len+1 words per command,
 * pad_word fill for short packets, surplus of long packets dropped
 * outputs and readies are sampled on the falling edge, inputs change on the rising edge
 */
`timescale 1ns/1ps

module gate_array_tb;

        import gate_cfg_pkg::*;

        // five traffic tests, each well under this many cycles
        localparam int max_test_cycles = 600;
        localparam int cycle_limit     = 5 * max_test_cycles + 1000;

        logic                             clk;
        logic                             reset;
        logic [lane_w-1:0]                cmd_lane;
        logic [len_w-1:0]                 cmd_len;
        logic [tag_w-1:0]                 cmd_tag;
        logic                             cmd_valid;
        logic                             cmd_ready;
        logic [num_lanes-1:0][data_w-1:0] lane_data;
        logic [num_lanes-1:0]             lane_last;
        logic [num_lanes-1:0]             lane_valid;
        logic [num_lanes-1:0]             lane_ready;
        logic [data_w-1:0]                m_data;
        logic                             m_first;
        logic                             m_last;
        logic [tag_w-1:0]                 m_tag;
        logic                             m_valid;
        logic                             m_ready;

        // ------------------------------
        // stimulus and scoreboard state
        // ------------------------------
        logic [lane_w-1:0] cmd_lane_q [$];
        logic [len_w-1:0]  cmd_len_q [$];
        logic [tag_w-1:0]  cmd_tag_q [$];
        // {last, data} per lane input word
        logic [32:0]       lane_q [num_lanes][$];
        // {first, last, data} of each output word by tag
        logic [33:0]       exp_q [256][$];
        logic [33:0]       got_q [256][$];
        logic [tag_w-1:0]  tags_used [$];

        int               exp_count;
        int               got_count;
        int               errors = 0;
        int               tests_passed = 0;
        int               tests_failed = 0;
        int               cycles = 0;
        logic             in_pkt = 1'b0;
        logic [tag_w-1:0] pkt_tag;
        logic [15:0]      lfsr = 16'd90;

        gate_array_top dut_i (
                .clk        (clk),
                .reset      (reset),
                .cmd_lane   (cmd_lane),
                .cmd_len    (cmd_len),
                .cmd_tag    (cmd_tag),
                .cmd_valid  (cmd_valid),
                .cmd_ready  (cmd_ready),
                .lane_data  (lane_data),
                .lane_last  (lane_last),
                .lane_valid (lane_valid),
                .lane_ready (lane_ready),
                .m_data     (m_data),
                .m_first    (m_first),
                .m_last     (m_last),
                .m_tag      (m_tag),
                .m_valid    (m_valid),
                .m_ready    (m_ready)
        );

        always #5 clk = ~clk;

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= cycle_limit) begin
                        $display("timeout: run stopped after %0d cycles", cycles);
                        $display("Simulation failed");
                        $finish;
                end
        end

        // 16-bit fibonacci lfsr with taps 16 14 13 11 and one step per bit
        function automatic logic [31:0] lfsr_bits(input int n);
                logic [31:0] r;
                logic        fb;
                r = '0;
                for (int i = 0; i < n; i++) begin
                        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
                        lfsr = {lfsr[14:0], fb};
                        r    = {r[30:0], fb};
                end
                return r;
        endfunction

        // output monitor that also checks packets do not interleave
        always @(negedge clk) begin
                if (!reset && m_valid && m_ready) begin
                        got_q[m_tag].push_back({m_first, m_last, m_data});
                        got_count++;
                        if (in_pkt) begin
                                if (m_tag != pkt_tag) begin
                                        $display("CHECK FAILED m_tag: expected %h, got %h",
                                                 pkt_tag, m_tag);
                                        errors++;
                                end
                        end else begin
                                pkt_tag = m_tag;
                        end
                        in_pkt = !m_last;
                end
        end

        task automatic clear_scoreboard();
                for (int i = 0; i < tags_used.size(); i++) begin
                        exp_q[tags_used[i]].delete();
                        got_q[tags_used[i]].delete();
                end
                tags_used.delete();
                exp_count = 0;
                got_count = 0;
        endtask

        // queue one command, its input packet and the words it should produce
        task automatic add_command(input logic [lane_w-1:0] lane, input int len,
                                   input logic [tag_w-1:0] tag, input int pkt_words);
                logic [31:0] pkt [$];
                logic [31:0] word;
                cmd_lane_q.push_back(lane);
                cmd_len_q.push_back(len_w'(len));
                cmd_tag_q.push_back(tag);
                for (int k = 0; k < pkt_words; k++) begin
                        word = lfsr_bits(32);
                        pkt.push_back(word);
                        lane_q[lane].push_back({k == pkt_words - 1, word});
                end
                for (int k = 0; k <= len; k++) begin
                        word = (k < pkt_words) ? pkt[k] : pad_word;
                        exp_q[tag].push_back({k == 0, k == len, word});
                end
                exp_count += len + 1;
                tags_used.push_back(tag);
        endtask

        // ------------------------------
        // drivers
        // ------------------------------
        task automatic drive_commands();
                while (cmd_lane_q.size() > 0) begin
                        cmd_lane  <= cmd_lane_q.pop_front();
                        cmd_len   <= cmd_len_q.pop_front();
                        cmd_tag   <= cmd_tag_q.pop_front();
                        cmd_valid <= 1'b1;
                        @(negedge clk);
                        while (!cmd_ready) @(negedge clk);
                        @(posedge clk);
                end
                cmd_valid <= 1'b0;
        endtask

        task automatic drive_lane(input logic [lane_w-1:0] lane);
                logic [32:0] w;
                while (lane_q[lane].size() > 0) begin
                        w = lane_q[lane].pop_front();
                        lane_data[lane]  <= w[31:0];
                        lane_last[lane]  <= w[32];
                        lane_valid[lane] <= 1'b1;
                        @(negedge clk);
                        while (!lane_ready[lane]) @(negedge clk);
                        @(posedge clk);
                end
                lane_valid[lane] <= 1'b0;
        endtask

        task automatic drive_ready(input logic bp);
                logic [31:0] bits;
                while (got_count < exp_count) begin
                        if (bp) begin
                                bits = lfsr_bits(1);
                                m_ready <= bits[0];
                        end else begin
                                m_ready <= 1'b1;
                        end
                        @(posedge clk);
                end
                m_ready <= 1'b1;
        endtask

        task automatic run_traffic(input logic bp);
                fork
                        drive_commands();
                        drive_lane(2'd0);
                        drive_lane(2'd1);
                        drive_lane(2'd2);
                        drive_lane(2'd3);
                        drive_ready(bp);
                join
                // idle time so that stray extra words would show up
                repeat (20) @(posedge clk);
        endtask

        // one output word of tag t against its expected value
        task automatic compare_word(input logic [tag_w-1:0] t, input int k,
                                    input logic [33:0] e, input logic [33:0] g);
                if (g[31:0] != e[31:0]) begin
                        $display("CHECK FAILED m_data: tag %h word %0d expected %h, got %h",
                                 t, k, e[31:0], g[31:0]);
                        errors++;
                end
                if (g[33] != e[33]) begin
                        $display("CHECK FAILED m_first: tag %h word %0d expected %h, got %h",
                                 t, k, e[33], g[33]);
                        errors++;
                end
                if (g[32] != e[32]) begin
                        $display("CHECK FAILED m_last: tag %h word %0d expected %h, got %h",
                                 t, k, e[32], g[32]);
                        errors++;
                end
        endtask

        task automatic check_outputs();
                logic [tag_w-1:0] t;
                if (got_count != exp_count) begin
                        $display("wrong number of output words: expected %0d, got %0d",
                                 exp_count, got_count);
                        errors++;
                end
                for (int i = 0; i < tags_used.size(); i++) begin
                        t = tags_used[i];
                        if (got_q[t].size() != exp_q[t].size()) begin
                                $display("tag %h delivered %0d words instead of %0d",
                                         t, got_q[t].size(), exp_q[t].size());
                                errors++;
                        end else begin
                                for (int k = 0; k < exp_q[t].size(); k++) begin
                                        compare_word(t, k, exp_q[t][k], got_q[t][k]);
                                end
                        end
                end
        endtask

        // control outputs are all low in reset, readies come up right after it
        task automatic check_control_outputs(input logic ready_exp);
                if (cmd_ready != ready_exp) begin
                        $display("CHECK FAILED cmd_ready: expected %h, got %h",
                                 ready_exp, cmd_ready);
                        errors++;
                end
                if (lane_ready != {num_lanes{ready_exp}}) begin
                        $display("CHECK FAILED lane_ready: expected %h, got %h",
                                 {num_lanes{ready_exp}}, lane_ready);
                        errors++;
                end
                if (m_valid != 1'b0) begin
                        $display("CHECK FAILED m_valid: expected %h, got %h", 1'b0, m_valid);
                        errors++;
                end
        endtask

        task automatic report_test(input string name, input int err0);
                if (errors == err0) begin
                        tests_passed++;
                        $display("test %s: ok", name);
                end else begin
                        tests_failed++;
                        $display("test %s: %0d errors", name, errors - err0);
                end
        endtask

        // ------------------------------
        // directed tests
        // ------------------------------
        task automatic test_reset();
                int err0;
                err0 = errors;
                repeat (4) @(posedge clk);
                @(negedge clk);
                check_control_outputs(1'b0);
                @(posedge clk);
                reset   <= 1'b0;
                m_ready <= 1'b1;
                @(negedge clk);
                check_control_outputs(1'b1);
                @(posedge clk);
                report_test("reset", err0);
        endtask

        task automatic test_exact_length();
                int err0;
                err0 = errors;
                clear_scoreboard();
                add_command(2'd0, 7, 8'h11, 8);
                run_traffic(1'b0);
                check_outputs();
                report_test("exact_length", err0);
        endtask

        task automatic test_padding();
                int err0;
                err0 = errors;
                clear_scoreboard();
                add_command(2'd1, 9, 8'h21, 4);
                run_traffic(1'b0);
                check_outputs();
                report_test("padding", err0);
        endtask

        task automatic test_surplus_drop();
                int err0;
                err0 = errors;
                clear_scoreboard();
                add_command(2'd2, 2, 8'h31, 7);
                add_command(2'd2, 2, 8'h32, 3);
                run_traffic(1'b0);
                check_outputs();
                report_test("surplus_drop", err0);
        endtask

        // exact, short and long packets on every lane and a second command on lanes 0 and 2
        task automatic load_mixed(input logic [tag_w-1:0] base);
                add_command(2'd0, 4, base, 5);
                add_command(2'd1, 5, base + 8'd1, 2);
                add_command(2'd2, 1, base + 8'd2, 6);
                add_command(2'd3, 11, base + 8'd3, 12);
                add_command(2'd0, 2, base + 8'd4, 1);
                add_command(2'd2, 3, base + 8'd5, 4);
        endtask

        task automatic test_all_lanes();
                int err0;
                err0 = errors;
                clear_scoreboard();
                load_mixed(8'h40);
                run_traffic(1'b0);
                check_outputs();
                report_test("all_lanes", err0);
        endtask

        task automatic test_back_pressure();
                int err0;
                err0 = errors;
                clear_scoreboard();
                load_mixed(8'h50);
                run_traffic(1'b1);
                check_outputs();
                report_test("back_pressure", err0);
        endtask

        initial begin
                clk        = 1'b0;
                reset      = 1'b1;
                cmd_lane   = '0;
                cmd_len    = '0;
                cmd_tag    = '0;
                cmd_valid  = 1'b0;
                lane_data  = '0;
                lane_last  = '0;
                lane_valid = '0;
                m_ready    = 1'b0;

                test_reset();
                test_exact_length();
                test_padding();
                test_surplus_drop();
                test_all_lanes();
                test_back_pressure();

                $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
                if (tests_failed == 0 && errors == 0) begin
                        $display("Simulation completed successfully");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

endmodule

//--- verilog.f
design/gate_cfg_pkg.sv
design/gate_types_pkg.sv
design/skid_stage.sv
design/permit_scheduler.sv
design/stream_gate.sv
design/packet_merger.sv
design/gate_array_top.sv
verification/gate_array_tb.sv
